/* logic/pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Data and instruction word width
`define WORD_W 16

// Register file index width and entry count
`define REG_ADDR_W 3
`define REG_COUNT (1 << `REG_ADDR_W)

// Instruction address width
`define PC_W 8

// Data memory uses the low address bits only
`define DMEM_ADDR_W 5
`define DMEM_DEPTH (1 << `DMEM_ADDR_W)

`endif

/* logic/pipe_pkg.sv */
`include "pipe_defines.svh"

package pipe_pkg;

	// Basic scalar types
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`PC_W-1:0] pc_t;

	// Opcode field, bits 15:11
	// R-type codes are contiguous so decode can derive the ALU op
	typedef enum logic [4:0] {
		OP_NOP  = 5'h00,
		OP_ADD  = 5'h01,
		OP_SUB  = 5'h02,
		OP_AND  = 5'h03,
		OP_XOR  = 5'h04,
		OP_ADDI = 5'h05,
		OP_LD   = 5'h06,
		OP_ST   = 5'h07,
		OP_J    = 5'h08
	} opcode_e;

	// ALU function, same order as the R-type opcodes
	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_XOR = 2'd3
	} alu_op_e;

	// What the hazard detector sees of an in-flight instruction
	typedef struct packed {
		logic      reg_write;
		reg_addr_t rd;
	} dest_t;

	// Decode to execute
	typedef struct packed {
		alu_op_e alu_op;
		word_t   a;
		word_t   b;
		word_t   store_data;
		dest_t   dest;
		logic    mem_read;
		logic    mem_write;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		word_t result;
		word_t store_data;
		dest_t dest;
		logic  mem_read;
		logic  mem_write;
	} ex_mem_t;

	// Memory to writeback, doubles as the retire record
	typedef struct packed {
		dest_t dest;
		word_t data;
	} mem_wb_t;

endpackage

/* logic/pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     hold,
	input  logic     bubble,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// Valid bit: bubble wins over hold
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (bubble) begin
			out_valid <= 1'b0;
		end else if (!hold) begin
			out_valid <= in_valid;
		end
	end

	// Payload only follows the hold
	always_ff @(posedge clk) begin
		if (!hold) begin
			out_data <= in_data;
		end
	end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
	input  logic          clk,
	input  logic          reset,
	input  logic          stall,
	input  logic          jump,
	input  pipe_pkg::pc_t jump_target,
	output pipe_pkg::pc_t imem_addr,
	output pipe_pkg::pc_t decode_pc,
	output logic          if_valid
);
	import pipe_pkg::*;

	pc_t pc;
	pc_t pc_next;

	// On stall ask the ROM again for the word sitting in decode
	assign imem_addr = stall ? decode_pc : pc;

	// Jump first, then hold on stall, else step
	always_comb begin
		if (jump) begin
			pc_next = jump_target;
		end else if (stall) begin
			pc_next = pc;
		end else begin
			pc_next = pc + pc_t'(1);
		end
	end

	// ROM answers one cycle later, so track the address it was given
	always_ff @(posedge clk) begin
		if (reset) begin
			pc        <= '0;
			decode_pc <= '0;
			if_valid  <= 1'b0;
		end else begin
			pc        <= pc_next;
			decode_pc <= imem_addr;
			// Word fetched behind a jump is squashed
			if_valid  <= ~jump;
		end
	end

endmodule

/* logic/hazard_detector.sv */
`timescale 1ns/10ps

module hazard_detector (
	input  pipe_pkg::reg_addr_t rs,
	input  pipe_pkg::reg_addr_t rt,
	input  logic                uses_rs,
	input  logic                uses_rt,
	input  pipe_pkg::dest_t     ex_dest,
	input  pipe_pkg::dest_t     mem_dest,
	input  pipe_pkg::dest_t     wb_dest,
	output logic                stall
);
	import pipe_pkg::*;

	function automatic logic conflicts(input dest_t d, input reg_addr_t s, input reg_addr_t t,
			input logic u_s, input logic u_t);
		return d.reg_write && ((u_s && d.rd == s) || (u_t && d.rd == t));
	endfunction

	// Hold decode until every in-flight writer of a source has left WB
	assign stall = conflicts(ex_dest, rs, rt, uses_rs, uses_rt) |
		conflicts(mem_dest, rs, rt, uses_rs, uses_rt) |
		conflicts(wb_dest, rs, rt, uses_rs, uses_rt);

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps
`include "pipe_defines.svh"

module decode_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              if_valid,
	input  pipe_pkg::word_t   instr,
	input  pipe_pkg::pc_t     decode_pc,
	input  logic              wb_valid,
	input  pipe_pkg::mem_wb_t wb,
	input  pipe_pkg::dest_t   ex_dest,
	input  pipe_pkg::dest_t   mem_dest,
	output logic              stall,
	output logic              jump,
	output pipe_pkg::pc_t     jump_target,
	output logic              id_ex_valid,
	output pipe_pkg::id_ex_t  id_ex
);
	import pipe_pkg::*;

	word_t     regs [`REG_COUNT];
	opcode_e   op;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm;
	logic      uses_rs;
	logic      uses_rt;
	logic      is_jump;
	dest_t     wb_dest;
	id_ex_t    decoded;

	// Instruction fields
	assign op  = opcode_e'(instr[15:11]);
	assign rs  = instr[10:8];
	assign rt  = instr[7:5];
	assign rd  = instr[4:2];
	assign imm = {{(`WORD_W-5){instr[4]}}, instr[4:0]};

	// Register file, written at the end of the retire cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid && wb.dest.reg_write) begin
			regs[wb.dest.rd] <= wb.data;
		end
	end

	// Control decode
	always_comb begin
		decoded            = '0;
		decoded.alu_op     = ALU_ADD;
		decoded.a          = regs[rs];
		decoded.b          = imm;
		decoded.store_data = regs[rt];
		uses_rs            = 1'b0;
		uses_rt            = 1'b0;
		is_jump            = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
				uses_rs                = 1'b1;
				uses_rt                = 1'b1;
				decoded.b              = regs[rt];
				// ALU op is the offset from OP_ADD
				decoded.alu_op         = alu_op_e'(op - OP_ADD);
				decoded.dest.reg_write = 1'b1;
				decoded.dest.rd        = rd;
			end
			OP_ADDI, OP_LD: begin
				uses_rs                = 1'b1;
				decoded.dest.reg_write = 1'b1;
				decoded.dest.rd        = rt;
				decoded.mem_read       = (op == OP_LD);
			end
			OP_ST: begin
				uses_rs           = 1'b1;
				uses_rt           = 1'b1;
				decoded.mem_write = 1'b1;
			end
			OP_J: begin
				is_jump = 1'b1;
			end
			default: begin
				// NOP and unused codes flow with no side effects
			end
		endcase
	end

	// Jump resolves here, target is pc+1+offset
	assign jump        = if_valid & is_jump;
	assign jump_target = decode_pc + pc_t'(1) + instr[`PC_W-1:0];

	// Writeback stage destination only counts while valid
	assign wb_dest = wb_valid ? wb.dest : '0;

	hazard_detector i_hazard_detector (
		.rs      (rs),
		.rt      (rt),
		.uses_rs (uses_rs & if_valid),
		.uses_rt (uses_rt & if_valid),
		.ex_dest (ex_dest),
		.mem_dest(mem_dest),
		.wb_dest (wb_dest),
		.stall   (stall)
	);

	// Bubble on stall, jumps never travel further
	pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
		.clk      (clk),
		.reset    (reset),
		.hold     (1'b0),
		.bubble   (stall),
		.in_valid (if_valid & ~is_jump),
		.in_data  (decoded),
		.out_valid(id_ex_valid),
		.out_data (id_ex)
	);

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  pipe_pkg::id_ex_t  in,
	output logic              out_valid,
	output pipe_pkg::ex_mem_t out,
	output pipe_pkg::dest_t   dest
);
	import pipe_pkg::*;

	word_t   alu_result;
	ex_mem_t ex_result;

	// ALU, also the address adder for LD and ST
	always_comb begin
		case (in.alu_op)
			ALU_ADD: alu_result = in.a + in.b;
			ALU_SUB: alu_result = in.a - in.b;
			ALU_AND: alu_result = in.a & in.b;
			default: alu_result = in.a ^ in.b;
		endcase
	end

	// Carry memory controls along with the result
	always_comb begin
		ex_result.result     = alu_result;
		ex_result.store_data = in.store_data;
		ex_result.dest       = in.dest;
		ex_result.mem_read   = in.mem_read;
		ex_result.mem_write  = in.mem_write;
	end

	// Instruction now in EX, seen by the hazard detector
	assign dest = in_valid ? in.dest : '0;

	pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
		.clk      (clk),
		.reset    (reset),
		.hold     (1'b0),
		.bubble   (1'b0),
		.in_valid (in_valid),
		.in_data  (ex_result),
		.out_valid(out_valid),
		.out_data (out)
	);

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/10ps
`include "pipe_defines.svh"

module memory_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  pipe_pkg::ex_mem_t in,
	output logic              out_valid,
	output pipe_pkg::mem_wb_t out,
	output pipe_pkg::dest_t   dest
);
	import pipe_pkg::*;

	word_t   dmem [`DMEM_DEPTH];
	logic    [`DMEM_ADDR_W-1:0] addr;
	mem_wb_t wb_next;

	// Word address from the low bits of the ALU result
	assign addr = in.result[`DMEM_ADDR_W-1:0];

	// Data memory, store lands at the edge
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (in_valid && in.mem_write) begin
			dmem[addr] <= in.store_data;
		end
	end

	// Load reads combinationally
	assign wb_next.dest = in.dest;
	assign wb_next.data = in.mem_read ? dmem[addr] : in.result;

	// Instruction now in MEM
	assign dest = in_valid ? in.dest : '0;

	// Only register writers reach MEM/WB and retire
	pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
		.clk      (clk),
		.reset    (reset),
		.hold     (1'b0),
		.bubble   (1'b0),
		.in_valid (in_valid & in.dest.reg_write),
		.in_data  (wb_next),
		.out_valid(out_valid),
		.out_data (out)
	);

endmodule

/* logic/pipeline_core.sv */
`timescale 1ns/10ps

module pipeline_core (
	input  logic              clk,
	input  logic              reset,
	output pipe_pkg::pc_t     imem_addr,
	input  pipe_pkg::word_t   imem_data,
	output logic              retire_valid,
	output pipe_pkg::mem_wb_t retire
);
	import pipe_pkg::*;

	// Fetch to decode
	logic    stall;
	logic    jump;
	pc_t     jump_target;
	pc_t     decode_pc;
	logic    if_valid;

	// Stage links
	logic    id_ex_valid;
	id_ex_t  id_ex;
	logic    ex_mem_valid;
	ex_mem_t ex_mem;

	// Hazard feedback
	dest_t   ex_dest;
	dest_t   mem_dest;

	fetch_unit i_fetch_unit (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.jump       (jump),
		.jump_target(jump_target),
		.imem_addr  (imem_addr),
		.decode_pc  (decode_pc),
		.if_valid   (if_valid)
	);

	// Retire port feeds the register file write
	decode_stage i_decode_stage (
		.clk        (clk),
		.reset      (reset),
		.if_valid   (if_valid),
		.instr      (imem_data),
		.decode_pc  (decode_pc),
		.wb_valid   (retire_valid),
		.wb         (retire),
		.ex_dest    (ex_dest),
		.mem_dest   (mem_dest),
		.stall      (stall),
		.jump       (jump),
		.jump_target(jump_target),
		.id_ex_valid(id_ex_valid),
		.id_ex      (id_ex)
	);

	execute_stage i_execute_stage (
		.clk      (clk),
		.reset    (reset),
		.in_valid (id_ex_valid),
		.in       (id_ex),
		.out_valid(ex_mem_valid),
		.out      (ex_mem),
		.dest     (ex_dest)
	);

	memory_stage i_memory_stage (
		.clk      (clk),
		.reset    (reset),
		.in_valid (ex_mem_valid),
		.in       (ex_mem),
		.out_valid(retire_valid),
		.out      (retire),
		.dest     (mem_dest)
	);

endmodule

/* verif/isa_model.sv */
`timescale 1ns/10ps
`include "pipe_defines.svh"

module isa_model #(
	parameter int PROG_LEN = 64
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [PROG_LEN*`WORD_W-1:0] program_bits,
	input  logic                        retire_valid,
	input  pipe_pkg::mem_wb_t           retire,
	output logic                        halted,
	output int                          mismatches,
	output int                          extra_retires,
	output int                          retired
);
	import pipe_pkg::*;

	// Architectural state
	word_t regs [`REG_COUNT];
	word_t dmem [`DMEM_DEPTH];
	int    pc;

	// Next writer the core has to retire
	logic  pending;
	dest_t exp_dest;
	word_t exp_data;
	// Spacing to the previous retirement, 0 when not pinned down
	int    exp_gap;
	logic  have_prev;
	// Destinations of the last three executed instructions, newest first
	dest_t hist [3];
	int    cycle;
	int    last_cycle;

	function automatic logic reads_dest(input dest_t d, input reg_addr_t rs,
			input reg_addr_t rt, input logic u_rs, input logic u_rt);
		return d.reg_write && ((u_rs && d.rd == rs) || (u_rt && d.rd == rt));
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Mismatch %s expected %h actual %h", name, expected, actual);
		mismatches++;
	endtask

	// Run ahead until the next register writer or the halt loop
	task automatic step_to_writer();
		word_t     ins;
		opcode_e   op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t     imm;
		word_t     addr;
		logic      u_rs;
		logic      u_rt;
		logic      dep_prev;
		logic      dep_any;
		dest_t     written;
		int        target;
		int        steps;
		steps   = 0;
		pending = 1'b0;
		while (!pending && !halted) begin
			ins      = program_bits[pc*`WORD_W +: `WORD_W];
			op       = opcode_e'(ins[15:11]);
			rs       = ins[10:8];
			rt       = ins[7:5];
			rd       = ins[4:2];
			imm      = {{(`WORD_W-5){ins[4]}}, ins[4:0]};
			addr     = regs[rs] + imm;
			u_rs     = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD, OP_ST};
			u_rt     = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ST};
			dep_prev = reads_dest(hist[0], rs, rt, u_rs, u_rt);
			dep_any  = dep_prev | reads_dest(hist[1], rs, rt, u_rs, u_rt) |
				reads_dest(hist[2], rs, rt, u_rs, u_rt);
			written  = '0;
			case (op)
				OP_ADD: exp_data = regs[rs] + regs[rt];
				OP_SUB: exp_data = regs[rs] - regs[rt];
				OP_AND: exp_data = regs[rs] & regs[rt];
				OP_XOR: exp_data = regs[rs] ^ regs[rt];
				OP_ADDI: exp_data = addr;
				OP_LD: exp_data = dmem[addr[`DMEM_ADDR_W-1:0]];
				OP_ST: dmem[addr[`DMEM_ADDR_W-1:0]] = regs[rt];
				default: begin
				end
			endcase
			if (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR}) begin
				written = '{1'b1, rd};
			end else if (op inside {OP_ADDI, OP_LD}) begin
				written = '{1'b1, rt};
			end
			if (written.reg_write) begin
				regs[written.rd] = exp_data;
				exp_dest = written;
				pending  = 1'b1;
				// Adjacent pair, a direct consumer waits for the producer to leave WB
				if (have_prev && steps == 0) begin
					exp_gap = dep_prev ? 4 : (dep_any ? 0 : 1);
				end else begin
					exp_gap = 0;
				end
				have_prev = 1'b1;
			end
			hist[2] = hist[1];
			hist[1] = hist[0];
			hist[0] = written;
			steps++;
			if (op == OP_J) begin
				target = pc + 1 + int'($signed(ins[10:0]));
				// A jump onto itself is the halt loop
				if (target == pc) begin
					halted = 1'b1;
				end
				pc = target;
			end else begin
				pc++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] = '0;
			end
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				dmem[i] = '0;
			end
			for (int i = 0; i < 3; i++) begin
				hist[i] = '0;
			end
			pc            = 0;
			halted        = 1'b0;
			have_prev     = 1'b0;
			cycle         = 0;
			last_cycle    = 0;
			mismatches    = 0;
			extra_retires = 0;
			retired       = 0;
			step_to_writer();
		end else begin
			cycle++;
			if (retire_valid) begin
				retired++;
				assert (pending)
				else begin
					$display("Retirement seen after the model reached the halt loop");
					extra_retires++;
				end
				if (pending) begin
					assert (retire.dest === exp_dest)
					else report_mismatch("retire_dest", 32'(exp_dest), 32'(retire.dest));
					assert (retire.data === exp_data)
					else report_mismatch("retire_data", 32'(exp_data), 32'(retire.data));
					if (exp_gap != 0) begin
						assert (cycle - last_cycle == exp_gap)
						else report_mismatch("retire_gap", exp_gap, cycle - last_cycle);
					end
					last_cycle = cycle;
					step_to_writer();
				end
			end
		end
	end

endmodule

/* verif/core_tb.sv */
`timescale 1ns/10ps
`include "pipe_defines.svh"

module core_tb;
	import pipe_pkg::*;

	localparam int PROG_LEN = 64;
	localparam int RESET_CYCLES = 16;
	// Every word stalling three cycles still fits well inside eight per word
	localparam int TIMEOUT_CYCLES = 8 * PROG_LEN + RESET_CYCLES;

	logic                        clk = 1'b0;
	logic                        reset;
	pc_t                         imem_addr;
	word_t                       imem_data;
	logic                        retire_valid;
	mem_wb_t                     retire;
	logic [PROG_LEN*`WORD_W-1:0] program_bits;
	logic                        halted;
	int                          mismatches;
	int                          extra_retires;
	int                          retired;
	int                          reset_errors = 0;
	int                          timeouts = 0;
	int                          cycles = 0;
	int                          post_reset = 0;

	// 100 ns clock
	always #50 clk = ~clk;

	pipeline_core i_pipeline_core (
		.clk         (clk),
		.reset       (reset),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.retire_valid(retire_valid),
		.retire      (retire)
	);

	isa_model #(.PROG_LEN(PROG_LEN)) i_isa_model (
		.clk          (clk),
		.reset        (reset),
		.program_bits (program_bits),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted),
		.mismatches   (mismatches),
		.extra_retires(extra_retires),
		.retired      (retired)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// Synchronous ROM, data follows the address by one cycle
	always @(posedge clk) begin
		if (imem_addr < pc_t'(PROG_LEN)) begin
			imem_data <= program_bits[imem_addr*`WORD_W +: `WORD_W];
		end else begin
			imem_data <= '0;
		end
	end

	// Quiet pipeline out of reset, first fetch from address 0
	always @(negedge clk) begin
		if (reset && cycles > 0) begin
			assert (retire_valid === 1'b0)
			else begin
				$display("Mismatch reset_retire_valid expected 0 actual %b", retire_valid);
				reset_errors++;
			end
			assert (imem_addr === '0)
			else begin
				$display("Mismatch reset_imem_addr expected 00 actual %h", imem_addr);
				reset_errors++;
			end
		end else if (!reset) begin
			post_reset++;
			if (post_reset == 1) begin
				assert (imem_addr === '0)
				else begin
					$display("Mismatch first_imem_addr expected 00 actual %h", imem_addr);
					reset_errors++;
				end
			end
			// Earliest retirement is four edges after the first decode
			if (post_reset <= 4) begin
				assert (retire_valid === 1'b0)
				else begin
					$display("Mismatch early_retire expected 0 actual %b", retire_valid);
					reset_errors++;
				end
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Half the time reuse a recent destination to provoke hazards
	function automatic reg_addr_t pick_reg(input logic [4:0] r, input reg_addr_t recent0,
			input reg_addr_t recent1);
		if (r[4]) begin
			return r[3] ? recent1 : recent0;
		end
		return r[2:0];
	endfunction

	task automatic build_program();
		logic [31:0] rnd;
		logic [3:0]  kind;
		logic [4:0]  imm;
		logic [2:0]  off;
		reg_addr_t   recent0;
		reg_addr_t   recent1;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		reg_addr_t   dest;
		logic        writes;
		word_t       ins;
		rnd = 32'h1460;
		recent0 = 3'd1;
		recent1 = 3'd2;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			rnd    = lcg_next(rnd);
			kind   = rnd[31:28];
			imm    = rnd[27:23];
			off    = {1'b0, rnd[22:21]} + 3'd1;
			rnd    = lcg_next(rnd);
			rs     = pick_reg(rnd[31:27], recent0, recent1);
			rt     = pick_reg(rnd[26:22], recent0, recent1);
			rd     = rnd[21:19];
			writes = 1'b1;
			dest   = rt;
			case (kind)
				4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
					ins  = {OP_ADD + 5'(kind[1:0]), rs, rt, rd, 2'b00};
					dest = rd;
				end
				4'd6, 4'd7, 4'd8, 4'd15: ins = {OP_ADDI, rs, rt, imm};
				4'd9, 4'd10: ins = {OP_LD, rs, rt, imm};
				4'd11, 4'd12: begin
					ins    = {OP_ST, rs, rt, imm};
					writes = 1'b0;
				end
				4'd13: begin
					writes = 1'b0;
					// Forward only and never past the halt word
					if (i + 1 + int'(off) <= PROG_LEN - 1) begin
						ins = {OP_J, 8'd0, off};
					end else begin
						ins = {OP_NOP, 11'd0};
					end
				end
				default: begin
					ins    = {OP_NOP, 11'd0};
					writes = 1'b0;
				end
			endcase
			program_bits[i*`WORD_W +: `WORD_W] = ins;
			if (writes) begin
				recent1 = recent0;
				recent0 = dest;
			end
		end
		// Halt loop, jump to itself
		program_bits[(PROG_LEN-1)*`WORD_W +: `WORD_W] = {OP_J, 11'h7FF};
	endtask

	initial begin
		reset        = 1'b1;
		imem_data    = '0;
		program_bits = '0;
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		while (!halted && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		if (halted) begin
			// Drain so a stray retirement behind the last writer still shows
			repeat (8) @(posedge clk);
		end else begin
			$display("Timeout after %0d cycles, halt loop never reached", cycles);
			timeouts++;
		end
		$display("Summary: %0d retired, %0d mismatches, %0d reset errors, %0d extra, %0d timeouts",
			retired, mismatches, reset_errors, extra_retires, timeouts);
		if (mismatches + reset_errors + extra_retires + timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+logic
logic/pipe_pkg.sv
logic/pipe_reg.sv
logic/fetch_unit.sv
logic/hazard_detector.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline_core.sv
verif/isa_model.sv
verif/core_tb.sv
